// File: logic/modexp_pkg.sv
/* shared widths, index types and state/opcode enums for the Montgomery exponentiator
   imported by every block of the design */
`default_nettype none

package modexp_pkg;

    localparam int WORD_WIDTH = 16;
    localparam int NUM_WORDS = 4;
    localparam int EXP_BITS = WORD_WIDTH * NUM_WORDS;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [2*WORD_WIDTH-1:0] dword_t;           // multiply-add result
    typedef logic [$clog2(NUM_WORDS)-1:0] word_idx_t;
    typedef logic [$clog2(NUM_WORDS+2)-1:0] vec_idx_t;  // partial-sum entries
    typedef logic [$clog2(EXP_BITS)-1:0] bit_idx_t;

    localparam word_idx_t LAST_WORD = word_idx_t'(NUM_WORDS - 1);
    localparam bit_idx_t TOP_BIT = bit_idx_t'(EXP_BITS - 1);

    // operand pair and destination of one Montgomery product
    typedef enum logic [1:0] {
        OP_TO_MONT,     // m * t -> m_bar
        OP_SQUARE,      // c_bar * c_bar -> c_bar
        OP_MULTIPLY,    // c_bar * m_bar -> c_bar
        OP_FROM_MONT    // 1 * c_bar -> c_bar
    } mont_op_t;

    typedef enum logic [3:0] {
        IDLE,
        LOADING,
        LOADED,
        TO_MONT,
        FIND_TOP,
        SQUARE,
        MULTIPLY,
        FROM_MONT,
        DONE,
        OUTPUT
    } ctrl_state_t;

    typedef enum logic [2:0] {
        MUL_ROW,        // v += a_i * b
        CARRY_TOP,
        FIND_Q,         // q = v0 * nprime0
        REDUCE_ROW,     // v = (v + q * n) >> w
        SHIFT_TOP,
        WRITE_BACK
    } engine_state_t;

endpackage

`default_nettype wire

// File: logic/store_if.sv
/* links from the operand store to its loader, the Montgomery engine and the controller */
`timescale 1ns/10ps
`default_nettype none

interface load_if;
    import modexp_pkg::*;

    logic we;
    word_idx_t index;
    word_t m_word, e_word, n_word, r_word, t_word;
    word_t nprime0;     // taken with word 0

    modport writer (output we, index, m_word, e_word, n_word, r_word, t_word, nprime0);
    modport store (input we, index, m_word, e_word, n_word, r_word, t_word, nprime0);
endinterface

interface mont_if;
    import modexp_pkg::*;

    mont_op_t op;
    word_idx_t a_idx, b_idx;
    logic wb_we;
    word_idx_t wb_idx;
    word_t wb_word;
    word_t a_word, b_word, n_word, nprime0;     // combinational returns

    modport engine (
        output op, a_idx, b_idx, wb_we, wb_idx, wb_word,
        input a_word, b_word, n_word, nprime0
    );
    modport store (
        input op, a_idx, b_idx, wb_we, wb_idx, wb_word,
        output a_word, b_word, n_word, nprime0
    );
endinterface

interface ctrl_if;
    import modexp_pkg::*;

    bit_idx_t bit_idx;
    word_idx_t res_idx;
    logic e_bit;
    word_t res_word;    // c_bar at res_idx

    modport controller (output bit_idx, res_idx, input e_bit, res_word);
    modport store (input bit_idx, res_idx, output e_bit, res_word);
endinterface

`default_nettype wire

// File: logic/operand_loader.sv
/* takes NUM_WORDS operand words after start_input, least significant first,
   and writes them into the operand store */
`timescale 1ns/10ps
`default_nettype none

module operand_loader (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_input,
    input  modexp_pkg::word_t m_word,
    input  modexp_pkg::word_t e_word,
    input  modexp_pkg::word_t n_word,
    input  modexp_pkg::word_t r_word,
    input  modexp_pkg::word_t t_word,
    input  modexp_pkg::word_t nprime0,
    input  logic              accept,
    output logic              load_done,
    load_if.writer            store
);
    import modexp_pkg::*;

    logic active;
    word_idx_t count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active <= 1'b0;
            count <= '0;
        end else if (!active) begin
            if (start_input && accept) begin
                active <= 1'b1;
                count <= '0;
            end
        end else begin
            count <= count + 1'b1;
            if (count == LAST_WORD) begin
                active <= 1'b0;
            end
        end
    end

    // one word per edge while active
    assign store.we = active;
    assign store.index = count;
    assign store.m_word = m_word;
    assign store.e_word = e_word;
    assign store.n_word = n_word;
    assign store.r_word = r_word;
    assign store.t_word = t_word;
    assign store.nprime0 = nprime0;

    assign load_done = active && (count == LAST_WORD);

endmodule

`default_nettype wire

// File: logic/operand_store.sv
/* operand and intermediate word arrays, with operand selection per Montgomery opcode
   written by the loader and the engine, read by the engine and the controller */
`timescale 1ns/10ps
`default_nettype none

module operand_store (
    input  logic   clk,
    input  logic   reset,
    load_if.store  load,
    mont_if.store  mont,
    ctrl_if.store  ctrl
);
    import modexp_pkg::*;

    word_t m_arr [NUM_WORDS];
    word_t n_arr [NUM_WORDS];
    word_t t_arr [NUM_WORDS];
    word_t m_bar [NUM_WORDS];
    word_t c_bar [NUM_WORDS];
    word_t nprime0_q;
    logic [EXP_BITS-1:0] e_bits;    // exponent kept flat for the bit scan

    always_ff @(posedge clk) begin
        if (load.we) begin
            m_arr[load.index] <= load.m_word;
            n_arr[load.index] <= load.n_word;
            t_arr[load.index] <= load.t_word;
            e_bits[load.index * WORD_WIDTH +: WORD_WIDTH] <= load.e_word;
            if (load.index == '0) begin
                nprime0_q <= load.nprime0;
            end
        end
        if (mont.wb_we && mont.op == OP_TO_MONT) begin
            m_bar[mont.wb_idx] <= mont.wb_word;
        end
    end

    // c_bar starts as r, then every product but the first lands here
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            c_bar <= '{default: '0};
        end else if (load.we) begin
            c_bar[load.index] <= load.r_word;
        end else if (mont.wb_we && mont.op != OP_TO_MONT) begin
            c_bar[mont.wb_idx] <= mont.wb_word;
        end
    end

    always_comb begin
        unique case (mont.op)
            OP_TO_MONT: begin
                mont.a_word = m_arr[mont.a_idx];
                mont.b_word = t_arr[mont.b_idx];
            end
            OP_SQUARE: begin
                mont.a_word = c_bar[mont.a_idx];
                mont.b_word = c_bar[mont.b_idx];
            end
            OP_MULTIPLY: begin
                mont.a_word = c_bar[mont.a_idx];
                mont.b_word = m_bar[mont.b_idx];
            end
            default: begin
                mont.a_word = (mont.a_idx == '0) ? word_t'(1) : '0;   // constant one
                mont.b_word = c_bar[mont.b_idx];
            end
        endcase
    end

    assign mont.n_word = n_arr[mont.b_idx];
    assign mont.nprime0 = nprime0_q;

    assign ctrl.e_bit = e_bits[ctrl.bit_idx];
    assign ctrl.res_word = c_bar[ctrl.res_idx];

endmodule

`default_nettype wire

// File: logic/mont_engine.sv
/* word-serial CIOS Montgomery product on a registered multiply-add
   started by go, operands and destination come from the store by opcode */
`timescale 1ns/10ps
`default_nettype none

module mont_engine (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 go,
    input  modexp_pkg::mont_op_t op,
    output logic                 done,
    mont_if.engine               store
);
    import modexp_pkg::*;

    engine_state_t state;
    logic busy;
    logic issued;       // capture half of a multiply-add step
    logic sweep;        // second pass of write-back
    logic borrow;
    logic need_sub;
    word_idx_t i, j;

    word_t v [NUM_WORDS+2];     // partial sum
    word_t carry;
    word_t q;
    dword_t mac_q;
    word_t mac_x, mac_y, mac_z, mac_c;
    vec_idx_t rd_idx;
    logic [WORD_WIDTH:0] sub;

    assign store.op = op;
    assign store.a_idx = i;
    assign store.b_idx = j;

    always_comb begin
        rd_idx = (state == CARRY_TOP || state == SHIFT_TOP) ? vec_idx_t'(NUM_WORDS)
                                                            : vec_idx_t'(j);
        mac_x = '0;
        mac_y = '0;
        mac_z = v[rd_idx];
        mac_c = carry;
        unique case (state)
            MUL_ROW: begin
                mac_x = store.a_word;
                mac_y = store.b_word;
            end
            FIND_Q: begin
                mac_x = v[0];
                mac_y = store.nprime0;
                mac_z = '0;
                mac_c = '0;
            end
            REDUCE_ROW: begin
                mac_x = q;
                mac_y = store.n_word;
            end
            default: ;      // top words only add the carry
        endcase
        if ((state == MUL_ROW || state == REDUCE_ROW) && j == '0) begin
            mac_c = '0;     // each row starts carry-free
        end
    end

    // final subtraction chain, first pass finds whether v >= n
    assign sub = {1'b0, v[j]} - {1'b0, store.n_word} - (WORD_WIDTH + 1)'(borrow);

    assign store.wb_we = busy && state == WRITE_BACK && sweep;
    assign store.wb_idx = j;
    assign store.wb_word = need_sub ? sub[WORD_WIDTH-1:0] : v[j];

    always_ff @(posedge clk) begin
        mac_q <= dword_t'(mac_x) * dword_t'(mac_y) + dword_t'(mac_z) + dword_t'(mac_c);
        if (!busy && go) begin
            v <= '{default: '0};
        end else if (busy && issued) begin
            unique case (state)
                MUL_ROW: begin
                    v[j] <= mac_q[WORD_WIDTH-1:0];
                    carry <= mac_q[2*WORD_WIDTH-1:WORD_WIDTH];
                end
                CARRY_TOP: begin
                    v[NUM_WORDS] <= mac_q[WORD_WIDTH-1:0];
                    v[NUM_WORDS+1] <= mac_q[2*WORD_WIDTH-1:WORD_WIDTH];
                end
                FIND_Q: q <= mac_q[WORD_WIDTH-1:0];
                REDUCE_ROW: begin
                    if (j != '0) begin
                        v[j - 1'b1] <= mac_q[WORD_WIDTH-1:0];   // shifted down one word
                    end
                    carry <= mac_q[2*WORD_WIDTH-1:WORD_WIDTH];
                end
                SHIFT_TOP: begin
                    v[NUM_WORDS-1] <= mac_q[WORD_WIDTH-1:0];
                    v[NUM_WORDS] <= v[NUM_WORDS+1] + mac_q[2*WORD_WIDTH-1:WORD_WIDTH];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= MUL_ROW;
            busy <= 1'b0;
            issued <= 1'b0;
            sweep <= 1'b0;
            borrow <= 1'b0;
            need_sub <= 1'b0;
            i <= '0;
            j <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (go) begin
                    busy <= 1'b1;
                    state <= MUL_ROW;
                    i <= '0;
                    j <= '0;
                end
            end else if (state == WRITE_BACK) begin
                borrow <= sub[WORD_WIDTH];
                j <= j + 1'b1;
                if (j == LAST_WORD) begin
                    j <= '0;
                    borrow <= 1'b0;
                    sweep <= !sweep;
                    if (!sweep) begin
                        need_sub <= (v[NUM_WORDS] != '0) || !sub[WORD_WIDTH];
                    end else begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end else if (!issued) begin
                issued <= 1'b1;
            end else begin
                issued <= 1'b0;
                unique case (state)
                    MUL_ROW, REDUCE_ROW: begin
                        j <= j + 1'b1;
                        if (j == LAST_WORD) begin
                            j <= '0;
                            state <= (state == MUL_ROW) ? CARRY_TOP : SHIFT_TOP;
                        end
                    end
                    CARRY_TOP: state <= FIND_Q;
                    FIND_Q: state <= REDUCE_ROW;
                    SHIFT_TOP: begin
                        i <= (i == LAST_WORD) ? '0 : i + 1'b1;
                        state <= (i == LAST_WORD) ? WRITE_BACK : MUL_ROW;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/exp_controller.sv
/* host command FSM, left-to-right exponent scan and result streaming
   issues one Montgomery product at a time to the engine */
`timescale 1ns/10ps
`default_nettype none

module exp_controller (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start_input,
    input  logic                 load_done,
    input  logic                 start_compute,
    input  logic                 get_result,
    output logic                 accept,
    output logic                 go,
    output modexp_pkg::mont_op_t op,
    input  logic                 engine_done,
    ctrl_if.controller           store,
    output logic                 done,
    output logic                 res_valid,
    output modexp_pkg::word_t    res_word
);
    import modexp_pkg::*;

    ctrl_state_t state;
    ctrl_state_t after;     // state once the running product ends
    logic launched;
    logic step_down;
    logic last_bit;
    bit_idx_t bit_idx;
    word_idx_t res_idx;

    assign last_bit = (bit_idx == '0);

    always_comb begin
        step_down = 1'b0;
        unique case (state)
            TO_MONT: after = FIND_TOP;
            SQUARE: begin
                after = store.e_bit ? MULTIPLY : (last_bit ? FROM_MONT : SQUARE);
                step_down = !store.e_bit && !last_bit;
            end
            MULTIPLY: begin
                after = last_bit ? FROM_MONT : SQUARE;
                step_down = !last_bit;
            end
            default: after = DONE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            launched <= 1'b0;
            go <= 1'b0;
            bit_idx <= '0;
            res_idx <= '0;
        end else begin
            go <= 1'b0;
            unique case (state)
                IDLE: if (start_input) state <= LOADING;
                LOADING: if (load_done) state <= LOADED;
                LOADED: begin
                    if (start_compute) begin
                        state <= TO_MONT;
                        bit_idx <= TOP_BIT;
                    end
                end
                TO_MONT, SQUARE, MULTIPLY, FROM_MONT: begin
                    if (!launched) begin
                        go <= 1'b1;     // engine is idle here
                        launched <= 1'b1;
                    end else if (engine_done) begin
                        launched <= 1'b0;
                        state <= after;
                        if (step_down) begin
                            bit_idx <= bit_idx - 1'b1;
                        end
                    end
                end
                FIND_TOP: begin
                    // e = 0 falls through with c_bar still r
                    if (store.e_bit) begin
                        state <= SQUARE;
                    end else if (last_bit) begin
                        state <= FROM_MONT;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end
                DONE: begin
                    if (get_result) begin
                        state <= OUTPUT;
                        res_idx <= '0;
                    end
                end
                OUTPUT: begin
                    res_idx <= res_idx + 1'b1;
                    if (res_idx == LAST_WORD) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_comb begin
        unique case (state)
            TO_MONT: op = OP_TO_MONT;
            SQUARE: op = OP_SQUARE;
            MULTIPLY: op = OP_MULTIPLY;
            default: op = OP_FROM_MONT;
        endcase
    end

    assign accept = (state == IDLE);
    assign done = (state == DONE);
    assign res_valid = (state == OUTPUT);
    assign res_word = store.res_word;   // least significant word first
    assign store.bit_idx = bit_idx;
    assign store.res_idx = res_idx;

endmodule

`default_nettype wire

// File: logic/modexp_top.sv
/* top level of the Montgomery modular exponentiator, result = m^e mod n
   host loads words, starts the compute, then reads the result words */
`timescale 1ns/10ps
`default_nettype none

module modexp_top (
    input  logic              clk,
    input  logic              reset,
    input  logic              start_input,
    input  logic              start_compute,
    input  logic              get_result,
    input  modexp_pkg::word_t m_word,
    input  modexp_pkg::word_t e_word,
    input  modexp_pkg::word_t n_word,
    input  modexp_pkg::word_t r_word,   // R mod n
    input  modexp_pkg::word_t t_word,   // R^2 mod n
    input  modexp_pkg::word_t nprime0,
    output logic              done,
    output logic              res_valid,
    output modexp_pkg::word_t res_word
);
    import modexp_pkg::*;

    logic accept;
    logic load_done;
    logic go;
    logic engine_done;
    mont_op_t op;

    load_if load_bus ();
    mont_if mont_bus ();
    ctrl_if ctrl_bus ();

    operand_loader u_loader (
        .clk, .reset, .start_input,
        .m_word, .e_word, .n_word, .r_word, .t_word, .nprime0,
        .accept, .load_done, .store(load_bus.writer)
    );

    operand_store u_store (
        .clk, .reset,
        .load(load_bus.store), .mont(mont_bus.store), .ctrl(ctrl_bus.store)
    );

    mont_engine u_engine (
        .clk, .reset, .go, .op, .done(engine_done), .store(mont_bus.engine)
    );

    exp_controller u_ctrl (
        .clk, .reset, .start_input, .load_done, .start_compute, .get_result,
        .accept, .go, .op, .engine_done, .store(ctrl_bus.controller),
        .done, .res_valid, .res_word
    );

endmodule

`default_nettype wire

// File: verification/modexp_model.svh
/* reference arithmetic for the exponentiator testbench, LFSR stepping and 128-bit modular math
   included inside the testbench module after the package import */
`ifndef MODEXP_MODEL_SVH
`define MODEXP_MODEL_SVH

typedef logic [EXP_BITS-1:0] operand_t;
typedef logic [2*EXP_BITS-1:0] product_t;

// galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
endfunction

function automatic operand_t mul_mod(input operand_t a, input operand_t b, input operand_t n);
    product_t product;
    product = product_t'(a) * product_t'(b);    // full 128-bit product
    return operand_t'(product % product_t'(n));
endfunction

// left-to-right square and multiply
function automatic operand_t pow_mod(input operand_t base, input operand_t exponent,
                                     input operand_t n);
    operand_t acc;
    int k;
    acc = operand_t'(1);    // n > 1
    for (k = EXP_BITS - 1; k >= 0; k--) begin
        acc = mul_mod(acc, acc, n);
        if (exponent[k]) begin
            acc = mul_mod(acc, base, n);
        end
    end
    return acc;
endfunction

// R mod n with R = 2^EXP_BITS
function automatic operand_t r_of_modulus(input operand_t n);
    product_t big;
    big = product_t'(1) << EXP_BITS;
    return operand_t'(big % product_t'(n));
endfunction

function automatic operand_t rsq_of_modulus(input operand_t n);
    operand_t r;
    r = r_of_modulus(n);
    return mul_mod(r, r, n);
endfunction

// -n^-1 mod 2^WORD_WIDTH, each newton step doubles the correct bits
function automatic word_t neg_inverse(input word_t n0);
    word_t x;
    int k;
    x = n0;     // right to 3 bits for odd n0
    for (k = 0; k < 4; k++) begin
        x = x * (word_t'(2) - n0 * x);
    end
    return -x;
endfunction

`endif

// File: verification/modexp_tb.sv
/* testbench for the Montgomery modular exponentiator
   runs random and edge operands through load, compute and readout, checked by assertions */
`timescale 1ns/10ps
`default_nettype none

module modexp_tb;
    import modexp_pkg::*;

    `include "modexp_model.svh"

    localparam int DONE_TIMEOUT = 40000;        // cycles, well above 130 products
    localparam int STREAM_TIMEOUT = 4 * NUM_WORDS;

    logic clk;
    logic reset;
    logic start_input;
    logic start_compute;
    logic get_result;
    word_t m_word, e_word, n_word, r_word, t_word, nprime0;
    logic done;
    logic res_valid;
    word_t res_word;

    logic quiet;                // done and res_valid must stay low
    logic [31:0] lfsr_state;
    word_t exp_words [NUM_WORDS];
    logic [$clog2(NUM_WORDS+1)-1:0] res_count;
    logic valid_last;
    operand_t m_val, n_val;

    modexp_top UUT (
        .clk, .reset, .start_input, .start_compute, .get_result,
        .m_word, .e_word, .n_word, .r_word, .t_word, .nprime0,
        .done, .res_valid, .res_word
    );

    always #4 clk = ~clk;

    // words seen so far in the current readout
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            res_count <= '0;
            valid_last <= 1'b0;
        end else begin
            valid_last <= res_valid;
            res_count <= res_valid ? res_count + 1'b1 : '0;
        end
    end

    assert property (@(negedge clk) reset |-> !done && !res_valid)
        else begin
            $display("error at %0t ns: done = %b, res_valid = %b in reset, expected 0 and 0",
                     $time, done, res_valid);
            abort_run();
        end

    assert property (@(negedge clk) disable iff (reset) quiet |-> !done)
        else begin
            $display("error at %0t ns: done = %b, expected 0", $time, done);
            abort_run();
        end

    assert property (@(negedge clk) disable iff (reset) quiet |-> !res_valid)
        else begin
            $display("error at %0t ns: res_valid = %b, expected 0", $time, res_valid);
            abort_run();
        end

    assert property (@(negedge clk) disable iff (reset) res_valid |-> res_count < NUM_WORDS)
        else begin
            $display("error at %0t ns: res_valid = 1 after %0d words, expected 0",
                     $time, res_count);
            abort_run();
        end

    assert property (@(negedge clk) disable iff (reset)
                     valid_last && !res_valid |-> res_count == NUM_WORDS)
        else begin
            $display("error at %0t ns: res_valid lasted %0d cycles, expected %0d",
                     $time, res_count, NUM_WORDS);
            abort_run();
        end

    assert property (@(negedge clk) disable iff (reset)
                     res_valid && res_count < NUM_WORDS
                     |-> res_word == exp_words[word_idx_t'(res_count)])
        else begin
            $display("error at %0t ns: res_word[%0d] = %h, expected %h", $time, res_count,
                     res_word, exp_words[word_idx_t'(res_count)]);
            abort_run();
        end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        abort_run();
    endtask

    function automatic operand_t random_bits(input int count);
        operand_t value;
        int k;
        value = '0;
        for (k = 0; k < count; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[EXP_BITS-2:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // odd modulus above one, base reduced below it
    task automatic new_random_operands(input int modulus_bits);
        n_val = random_bits(modulus_bits) | operand_t'(1);
        if (n_val == operand_t'(1)) begin
            n_val = operand_t'(3);
        end
        m_val = random_bits(EXP_BITS) % n_val;
    endtask

    task automatic pulse_start_compute();
        @(negedge clk);
        start_compute = 1'b1;
        @(negedge clk);
        start_compute = 1'b0;
    endtask

    task automatic pulse_get_result();
        @(negedge clk);
        get_result = 1'b1;
        @(negedge clk);
        get_result = 1'b0;
    endtask

    // start_input, then one word per cycle, least significant first
    task automatic load_operands(input operand_t m, input operand_t e, input operand_t n,
                                 input operand_t r, input operand_t t, input word_t np0);
        int w;
        @(negedge clk);
        start_input = 1'b1;
        @(negedge clk);
        start_input = 1'b0;
        for (w = 0; w < NUM_WORDS; w++) begin
            m_word = m[w*WORD_WIDTH +: WORD_WIDTH];
            e_word = e[w*WORD_WIDTH +: WORD_WIDTH];
            n_word = n[w*WORD_WIDTH +: WORD_WIDTH];
            r_word = r[w*WORD_WIDTH +: WORD_WIDTH];
            t_word = t[w*WORD_WIDTH +: WORD_WIDTH];
            nprime0 = (w == 0) ? np0 : ~np0;    // valid with word 0 only
            @(negedge clk);
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > DONE_TIMEOUT) begin
                timeout_abort("done after start_compute");
            end
        end
    endtask

    task automatic read_result();
        int cycles;
        cycles = 0;
        while (!res_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > STREAM_TIMEOUT) begin
                timeout_abort("res_valid after get_result");
            end
        end
        cycles = 0;
        while (res_valid) begin
            @(negedge clk);
            cycles++;
            if (cycles > STREAM_TIMEOUT) begin
                timeout_abort("the end of the result words");
            end
        end
    endtask

    // disturb adds get_result pulses before and during the compute
    task automatic run_case(input operand_t m, input operand_t e, input operand_t n,
                            input logic disturb);
        operand_t expected;
        int w;
        expected = pow_mod(m, e, n);
        for (w = 0; w < NUM_WORDS; w++) begin
            exp_words[w] = expected[w*WORD_WIDTH +: WORD_WIDTH];
        end
        load_operands(m, e, n, r_of_modulus(n), rsq_of_modulus(n), neg_inverse(n[WORD_WIDTH-1:0]));
        if (disturb) begin
            pulse_get_result();     // LOADED ignores it
        end
        pulse_start_compute();
        if (disturb) begin
            pulse_get_result();     // engine still busy
        end
        quiet = 1'b0;
        wait_done();
        pulse_get_result();
        read_result();
        quiet = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        start_input = 1'b0;
        start_compute = 1'b0;
        get_result = 1'b0;
        m_word = '0;
        e_word = '0;
        n_word = '0;
        r_word = '0;
        t_word = '0;
        nprime0 = '0;
        quiet = 1'b1;
        lfsr_state = 32'hb15501cd;
        exp_words = '{default: '0};
        repeat (8) @(negedge clk);
        reset = 1'b0;

        repeat (20) @(negedge clk);     // idle, no commands

        repeat (10) begin
            new_random_operands(EXP_BITS);
            run_case(m_val, random_bits(EXP_BITS), n_val, 1'b0);
        end

        // edge exponents
        new_random_operands(EXP_BITS);
        run_case(m_val, '0, n_val, 1'b0);
        run_case(m_val, operand_t'(1), n_val, 1'b0);
        run_case(m_val, operand_t'(1) << (EXP_BITS - 1), n_val, 1'b0);

        // commands out of order, nothing loaded yet
        pulse_start_compute();
        pulse_get_result();
        repeat (10) @(negedge clk);
        new_random_operands(EXP_BITS);
        run_case(m_val, random_bits(EXP_BITS), n_val, 1'b1);

        // back to back with small moduli
        repeat (3) begin
            new_random_operands(20);
            run_case(m_val, random_bits(EXP_BITS), n_val, 1'b0);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verification
logic/modexp_pkg.sv
logic/store_if.sv
logic/operand_loader.sv
logic/operand_store.sv
logic/mont_engine.sv
logic/exp_controller.sv
logic/modexp_top.sv
verification/modexp_tb.sv

// File: Makefile
# Verilator build and run of the modular exponentiator testbench
# the simulator exits nonzero when the testbench stops with $fatal

BUILD_DIR = build

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --assert --timing -Wno-fatal --top-module modexp_tb \
		-f src.f -Mdir $(BUILD_DIR) -o modexp_sim
	./$(BUILD_DIR)/modexp_sim

clean:
	rm -rf $(BUILD_DIR)
